/* smartnic_pkg.sv */
package smartnic_pkg;

    // ========================================================================
    // Port numbering
    // ========================================================================

    // Switch side ingress/egress ports seen by the core
    localparam int NUM_PORTS = 4;

    // Port number carried on tid (ingress) and tdest (egress)
    typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

    // ========================================================================
    // Stream geometry
    // ========================================================================

    // Bits per tkeep lane
    localparam int BYTE_WID = 8;

    // Default tdata width in bytes, one tkeep bit per byte
    localparam int DEFAULT_DATA_BYTE_WID = 8;

endpackage : smartnic_pkg

/* steer_reg_pkg.sv */
package steer_reg_pkg;
    import smartnic_pkg::*;

    // ========================================================================
    // Register word and address types
    // ========================================================================

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // One route table entry per ingress port
    typedef struct packed {
        logic  drop;
        port_t dest;
    } route_entry_t;

    // ========================================================================
    // Register map
    // ========================================================================

    // Global control, bit 0 enables forwarding
    localparam reg_addr_t CTRL_ADDR       = 8'h00;
    localparam int        CTRL_ENABLE_BIT = 0;

    // Per-port blocks, one word per port
    localparam reg_addr_t ROUTE_BASE    = 8'h10;
    localparam reg_addr_t FWD_CNT_BASE  = 8'h20;
    localparam reg_addr_t DROP_CNT_BASE = 8'h30;
    localparam int        REG_STRIDE    = 4;

    // Route entry fields within a register word
    localparam int ROUTE_DROP_BIT = 8;
    localparam int ROUTE_DEST_LSB = 0;

endpackage : steer_reg_pkg

/* axis_if.sv */
`timescale 1ns/1ps

interface axis_if import smartnic_pkg::*; #(
    parameter int DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID
) ();

    logic                              tvalid;
    logic                              tready;
    logic [DATA_BYTE_WID*BYTE_WID-1:0] tdata;
    logic [DATA_BYTE_WID-1:0]          tkeep;
    logic                              tlast;
    port_t                             tid;
    port_t                             tdest;

    // Upstream side, drives the beat
    modport source (
        output tvalid, tdata, tkeep, tlast, tid, tdest,
        input  tready
    );

    // Downstream side, applies back-pressure
    modport sink (
        input  tvalid, tdata, tkeep, tlast, tid, tdest,
        output tready
    );

endinterface : axis_if

/* steer_cfg_if.sv */
`timescale 1ns/1ps

interface steer_cfg_if import smartnic_pkg::*, steer_reg_pkg::*; ();

    // Configuration from the register block
    logic         enable;
    route_entry_t route [NUM_PORTS];

    // Per-packet events from the datapath, one cycle each
    logic         fwd_pulse;
    logic         drop_pulse;
    port_t        event_port;

    modport regs (
        output enable, route,
        input  fwd_pulse, drop_pulse, event_port
    );

    modport datapath (
        input  enable, route,
        output fwd_pulse, drop_pulse, event_port
    );

endinterface : steer_cfg_if

/* steer_regs.sv */
`timescale 1ns/1ps

module steer_regs import smartnic_pkg::*, steer_reg_pkg::*; (
    input  logic        axil_if,
    input  logic        arst_n,

    // AXI-Lite write
    input  logic        awvalid,
    output logic        awready,
    input  reg_addr_t   awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  reg_data_t   wdata,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,

    // AXI-Lite read
    input  logic        arvalid,
    output logic        arready,
    input  reg_addr_t   araddr,
    output logic        rvalid,
    input  logic        rready,
    output reg_data_t   rdata,
    output logic [1:0]  rresp,

    steer_cfg_if.regs   cfg
);

    // Word index and block base within the map
    localparam int IDX_LSB = $clog2(REG_STRIDE);
    localparam int BLK_LSB = IDX_LSB + $bits(port_t);

    logic         enable_q;
    route_entry_t route_q    [NUM_PORTS];
    reg_data_t    fwd_cnt    [NUM_PORTS];
    reg_data_t    drop_cnt   [NUM_PORTS];

    logic         wr_fire;
    logic         wr_is_ctrl;
    reg_addr_t    wr_blk;
    port_t        wr_idx;
    logic         rd_fire;
    logic         rd_is_ctrl;
    reg_addr_t    rd_blk;
    port_t        rd_idx;
    reg_data_t    rd_word;

    // ========================================================================
    // Address decode
    // ========================================================================

    assign wr_is_ctrl = (awaddr >> IDX_LSB) == (CTRL_ADDR >> IDX_LSB);
    assign wr_blk     = reg_addr_t'((awaddr >> BLK_LSB) << BLK_LSB);
    assign wr_idx     = port_t'(awaddr >> IDX_LSB);

    assign rd_is_ctrl = (araddr >> IDX_LSB) == (CTRL_ADDR >> IDX_LSB);
    assign rd_blk     = reg_addr_t'((araddr >> BLK_LSB) << BLK_LSB);
    assign rd_idx     = port_t'(araddr >> IDX_LSB);

    // ========================================================================
    // Handshakes
    // ========================================================================

    // Address and data taken together, only with no response pending
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ========================================================================
    // Configuration and counters
    // ========================================================================

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            enable_q <= 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                route_q[i]  <= '0;
                fwd_cnt[i]  <= '0;
                drop_cnt[i] <= '0;
            end
        end else begin
            // Counter blocks are read only
            if (wr_fire) begin
                if (wr_is_ctrl) begin
                    enable_q <= wdata[CTRL_ENABLE_BIT];
                end else if (wr_blk == ROUTE_BASE) begin
                    route_q[wr_idx].drop <= wdata[ROUTE_DROP_BIT];
                    route_q[wr_idx].dest <= wdata[ROUTE_DEST_LSB +: $bits(port_t)];
                end
            end
            if (cfg.fwd_pulse) begin
                fwd_cnt[cfg.event_port] <= fwd_cnt[cfg.event_port] + 1'b1;
            end
            if (cfg.drop_pulse) begin
                drop_cnt[cfg.event_port] <= drop_cnt[cfg.event_port] + 1'b1;
            end
        end
    end

    assign cfg.enable = enable_q;
    assign cfg.route  = route_q;

    // Read mux, holes in the map read as zero
    always_comb begin
        rd_word = '0;
        if (rd_is_ctrl) begin
            rd_word[CTRL_ENABLE_BIT] = enable_q;
        end else begin
            case (rd_blk)
                ROUTE_BASE: begin
                    rd_word[ROUTE_DROP_BIT]                    = route_q[rd_idx].drop;
                    rd_word[ROUTE_DEST_LSB +: $bits(port_t)] = route_q[rd_idx].dest;
                end
                FWD_CNT_BASE:  rd_word = fwd_cnt[rd_idx];
                DROP_CNT_BASE: rd_word = drop_cnt[rd_idx];
                default:       rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge axil_if) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

    // ========================================================================
    // Assertions
    // ========================================================================

    a_bvalid_hold : assert property (
        @(posedge axil_if) disable iff (!arst_n)
        bvalid && !bready |=> bvalid
    );

    // A packet is either forwarded or dropped, never both
    a_pulse_excl : assert property (
        @(posedge axil_if) disable iff (!arst_n)
        !(cfg.fwd_pulse && cfg.drop_pulse)
    );

endmodule : steer_regs

/* port_steer.sv */
`timescale 1ns/1ps

module port_steer import smartnic_pkg::*, steer_reg_pkg::*; #(
    parameter int DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID
) (
    input  logic            axil_if,
    input  logic            arst_n,
    axis_if.sink            axis_in,
    axis_if.source          axis_out,
    steer_cfg_if.datapath   cfg
);

    localparam int DATA_WID = DATA_BYTE_WID * BYTE_WID;

    // Packet state
    logic                     in_pkt;
    logic                     fwd_q;
    port_t                    dest_q;

    // Decision for the current beat
    route_entry_t             head_entry;
    logic                     head_fwd;
    logic                     first_beat;
    logic                     cur_fwd;
    port_t                    cur_dest;
    logic                     in_xfer;

    // Output register
    logic                     out_valid;
    logic [DATA_WID-1:0]      out_data;
    logic [DATA_BYTE_WID-1:0] out_keep;
    logic                     out_last;
    port_t                    out_id;
    port_t                    out_dest;

    // ========================================================================
    // Route lookup
    // ========================================================================

    assign first_beat = !in_pkt;
    assign head_entry = cfg.route[axis_in.tid];
    assign head_fwd   = cfg.enable && !head_entry.drop;

    // Head of packet uses live config, later beats the latched decision
    assign cur_fwd  = first_beat ? head_fwd : fwd_q;
    assign cur_dest = first_beat ? head_entry.dest : dest_q;

    // Dropped beats never wait on the output
    assign axis_in.tready = cur_fwd ? (!out_valid || axis_out.tready) : 1'b1;
    assign in_xfer        = axis_in.tvalid && axis_in.tready;

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt <= 1'b0;
            fwd_q  <= 1'b0;
            dest_q <= '0;
        end else if (in_xfer) begin
            in_pkt <= !axis_in.tlast;
            if (first_beat) begin
                fwd_q  <= head_fwd;
                dest_q <= head_entry.dest;
            end
        end
    end

    // One event per packet, on the accepted head beat
    assign cfg.fwd_pulse  = in_xfer && first_beat && head_fwd;
    assign cfg.drop_pulse = in_xfer && first_beat && !head_fwd;
    assign cfg.event_port = axis_in.tid;

    // ========================================================================
    // Output register
    // ========================================================================

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_xfer && cur_fwd) begin
            out_valid <= 1'b1;
        end else if (axis_out.tready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge axil_if) begin
        if (in_xfer && cur_fwd) begin
            out_data <= axis_in.tdata;
            out_keep <= axis_in.tkeep;
            out_last <= axis_in.tlast;
            out_id   <= axis_in.tid;
            out_dest <= cur_dest;
        end
    end

    assign axis_out.tvalid = out_valid;
    assign axis_out.tdata  = out_data;
    assign axis_out.tkeep  = out_keep;
    assign axis_out.tlast  = out_last;
    assign axis_out.tid    = out_id;
    assign axis_out.tdest  = out_dest;

    // ========================================================================
    // Assertions
    // ========================================================================

    // Stalled beat must not change until taken
    a_out_stable : assert property (
        @(posedge axil_if) disable iff (!arst_n)
        axis_out.tvalid && !axis_out.tready |=>
            axis_out.tvalid && $stable(axis_out.tdata) && $stable(axis_out.tkeep) &&
            $stable(axis_out.tlast) && $stable(axis_out.tid) && $stable(axis_out.tdest)
    );

endmodule : port_steer

/* steer_core.sv */
`timescale 1ns/1ps

module steer_core import smartnic_pkg::*, steer_reg_pkg::*; #(
    parameter int DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID
) (
    input  logic                              axil_if,
    input  logic                              arst_n,

    // AXI-Lite management
    input  logic                              awvalid,
    output logic                              awready,
    input  reg_addr_t                         awaddr,
    input  logic                              wvalid,
    output logic                              wready,
    input  reg_data_t                         wdata,
    output logic                              bvalid,
    input  logic                              bready,
    output logic [1:0]                        bresp,
    input  logic                              arvalid,
    output logic                              arready,
    input  reg_addr_t                         araddr,
    output logic                              rvalid,
    input  logic                              rready,
    output reg_data_t                         rdata,
    output logic [1:0]                        rresp,

    // Stream from the switch
    input  logic                              s_tvalid,
    output logic                              s_tready,
    input  logic [DATA_BYTE_WID*BYTE_WID-1:0] s_tdata,
    input  logic [DATA_BYTE_WID-1:0]          s_tkeep,
    input  logic                              s_tlast,
    input  port_t                             s_tid,

    // Stream to the core
    output logic                              m_tvalid,
    input  logic                              m_tready,
    output logic [DATA_BYTE_WID*BYTE_WID-1:0] m_tdata,
    output logic [DATA_BYTE_WID-1:0]          m_tkeep,
    output logic                              m_tlast,
    output port_t                             m_tid,
    output port_t                             m_tdest
);

    axis_if #(.DATA_BYTE_WID(DATA_BYTE_WID)) axis_in  ();
    axis_if #(.DATA_BYTE_WID(DATA_BYTE_WID)) axis_out ();
    steer_cfg_if                             cfg      ();

    // Ingress has no destination yet
    assign axis_in.tvalid = s_tvalid;
    assign axis_in.tdata  = s_tdata;
    assign axis_in.tkeep  = s_tkeep;
    assign axis_in.tlast  = s_tlast;
    assign axis_in.tid    = s_tid;
    assign axis_in.tdest  = '0;
    assign s_tready       = axis_in.tready;

    assign m_tvalid        = axis_out.tvalid;
    assign m_tdata         = axis_out.tdata;
    assign m_tkeep         = axis_out.tkeep;
    assign m_tlast         = axis_out.tlast;
    assign m_tid           = axis_out.tid;
    assign m_tdest         = axis_out.tdest;
    assign axis_out.tready = m_tready;

    steer_regs u_regs (
        .axil_if (axil_if),
        .arst_n  (arst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .cfg     (cfg.regs)
    );

    port_steer #(
        .DATA_BYTE_WID (DATA_BYTE_WID)
    ) u_steer (
        .axil_if  (axil_if),
        .arst_n   (arst_n),
        .axis_in  (axis_in.sink),
        .axis_out (axis_out.source),
        .cfg      (cfg.datapath)
    );

endmodule : steer_core

/* tb.sv */
`timescale 1ns/1ps

module tb import smartnic_pkg::*, steer_reg_pkg::*; ();

    localparam int          DATA_BYTE_WID = DEFAULT_DATA_BYTE_WID;
    localparam int          DATA_WID      = DATA_BYTE_WID * BYTE_WID;
    localparam int          FWD_PKTS      = 40;
    localparam int          OFF_PKTS      = 8;
    localparam int          MAX_BEATS     = 6;
    localparam int          WDOG_CYCLES   = (FWD_PKTS + OFF_PKTS) * MAX_BEATS * 40 + 2000;
    localparam logic [31:0] SEED          = 32'd89;
    localparam logic [1:0]  RESP_OKAY     = 2'b00;

    typedef struct packed {
        logic [DATA_WID-1:0]      data;
        logic [DATA_BYTE_WID-1:0] keep;
        logic                     last;
        port_t                    id;
        port_t                    dest;
    } beat_t;

    logic                     axil_if;
    logic                     arst_n;
    logic                     awvalid, awready, wvalid, wready, bvalid, bready;
    logic                     arvalid, arready, rvalid, rready;
    reg_addr_t                awaddr, araddr;
    reg_data_t                wdata, rdata;
    logic [1:0]               bresp, rresp;
    logic                     s_tvalid, s_tready, s_tlast;
    logic [DATA_WID-1:0]      s_tdata;
    logic [DATA_BYTE_WID-1:0] s_tkeep;
    port_t                    s_tid;
    logic                     m_tvalid, m_tready, m_tlast;
    logic [DATA_WID-1:0]      m_tdata;
    logic [DATA_BYTE_WID-1:0] m_tkeep;
    port_t                    m_tid, m_tdest;

    // Model state, mirrors of what the DUT should hold
    logic [31:0]  stim_state = SEED;
    logic [31:0]  rdy_state  = SEED;
    logic         enable_m;
    route_entry_t route_m [NUM_PORTS];
    reg_data_t    fwd_m   [NUM_PORTS];
    reg_data_t    drop_m  [NUM_PORTS];
    beat_t        exp_q   [$];
    beat_t        exp_b;

    steer_core #(.DATA_BYTE_WID(DATA_BYTE_WID)) DUT (.*);

    initial begin
        axil_if = 1'b0;
        forever #10 axil_if = ~axil_if;
    end

    // ========================================================================
    // Reference model and helpers
    // ========================================================================

    function automatic logic [31:0] lcg_step(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // Drop when disabled or flagged, otherwise forward to the entry's dest
    function automatic route_entry_t route_ref(input logic en,
                                               input route_entry_t tbl [NUM_PORTS],
                                               input port_t tid);
        route_entry_t r;
        r      = tbl[tid];
        r.drop = !en || tbl[tid].drop;
        return r;
    endfunction

    function automatic reg_addr_t port_addr(input reg_addr_t base, input int p);
        return reg_addr_t'(base + p * REG_STRIDE);
    endfunction

    function automatic reg_data_t route_word(input route_entry_t e);
        reg_data_t w;
        w                                   = '0;
        w[ROUTE_DROP_BIT]                   = e.drop;
        w[ROUTE_DEST_LSB +: $bits(port_t)] = e.dest;
        return w;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic [1:0] got);
        if (got !== RESP_OKAY)
            stop_on_error($sformatf("CHECK FAILED %s got %h expected %h",
                                    name, got, RESP_OKAY));
    endtask

    task automatic check_beat(input logic [DATA_WID-1:0] data,
                              input logic [DATA_BYTE_WID-1:0] keep,
                              input logic last, input port_t id, input port_t dest,
                              input beat_t exp);
        if (data !== exp.data)
            stop_on_error($sformatf("CHECK FAILED m_tdata got %h expected %h", data, exp.data));
        if (keep !== exp.keep)
            stop_on_error($sformatf("CHECK FAILED m_tkeep got %h expected %h", keep, exp.keep));
        if (last !== exp.last)
            stop_on_error($sformatf("CHECK FAILED m_tlast got %h expected %h", last, exp.last));
        if (id !== exp.id)
            stop_on_error($sformatf("CHECK FAILED m_tid got %h expected %h", id, exp.id));
        if (dest !== exp.dest)
            stop_on_error($sformatf("CHECK FAILED m_tdest got %h expected %h", dest, exp.dest));
    endtask

    task automatic axil_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge axil_if);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        do begin
            @(posedge axil_if);
        end while (!awready && !wready);
        if (awready !== 1'b1 || wready !== 1'b1)
            stop_on_error("Write address and data were not accepted in the same cycle");
        @(negedge axil_if);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (bvalid !== 1'b1)
            stop_on_error("No write response in the cycle after the write was accepted");
        check_resp("bresp", bresp);
    endtask

    task automatic read_expect(input reg_addr_t addr, input reg_data_t exp, input string name);
        @(negedge axil_if);
        arvalid = 1'b1;
        araddr  = addr;
        do begin
            @(posedge axil_if);
        end while (!arready);
        @(negedge axil_if);
        arvalid = 1'b0;
        if (rvalid !== 1'b1)
            stop_on_error("No read data in the cycle after the read was accepted");
        check_resp("rresp", rresp);
        check_reg(name, rdata, exp);
    endtask

    // Expected beats are queued before the packet enters the DUT
    task automatic send_packet(input port_t tid, input int len);
        route_entry_t r;
        beat_t        b;
        logic [31:0]  rnd;
        r = route_ref(enable_m, route_m, tid);
        if (r.drop)
            drop_m[tid] = drop_m[tid] + 1;
        else
            fwd_m[tid] = fwd_m[tid] + 1;
        for (int i = 0; i < len; i++) begin
            rnd    = lcg_step(stim_state);
            b.data = DATA_WID'({lcg_step(stim_state), rnd});
            b.last = (i == len - 1);
            b.keep = b.last ? {DATA_BYTE_WID{1'b1}} >> rnd[2:0] : {DATA_BYTE_WID{1'b1}};
            b.id   = tid;
            b.dest = r.dest;
            if (!r.drop)
                exp_q.push_back(b);
            @(negedge axil_if);
            s_tvalid = 1'b1;
            s_tdata  = b.data;
            s_tkeep  = b.keep;
            s_tlast  = b.last;
            s_tid    = tid;
            do begin
                @(posedge axil_if);
            end while (!s_tready);
        end
        @(negedge axil_if);
        s_tvalid = 1'b0;
    endtask

    // ========================================================================
    // Back-pressure, compare and watchdog
    // ========================================================================

    // Ready roughly three cycles in four
    initial begin
        logic [31:0] rnd;
        forever begin
            @(negedge axil_if);
            rnd      = lcg_step(rdy_state);
            m_tready = arst_n && (rnd[17:16] != 2'b00);
        end
    end

    always @(posedge axil_if) begin
        if (arst_n && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                stop_on_error("An output beat appeared while no forwarded beat was expected");
            end else begin
                exp_b = exp_q.pop_front();
                check_beat(m_tdata, m_tkeep, m_tlast, m_tid, m_tdest, exp_b);
            end
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge axil_if);
        stop_on_error("Timeout: the test sequence did not finish in the expected time");
    end

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        logic [31:0] rnd;
        arst_n   = 1'b0;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        bready   = 1'b1;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b1;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tlast  = 1'b0;
        s_tid    = '0;
        m_tready = 1'b0;
        enable_m = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            route_m[p] = '0;
            fwd_m[p]   = '0;
            drop_m[p]  = '0;
        end
        repeat (16) @(posedge axil_if);
        @(negedge axil_if);
        arst_n = 1'b1;
        if (bvalid !== 1'b0 || rvalid !== 1'b0 || m_tvalid !== 1'b0)
            stop_on_error("A valid output was not low after reset");

        // Reset values
        read_expect(CTRL_ADDR, '0, "ctrl");
        for (int p = 0; p < NUM_PORTS; p++) begin
            read_expect(port_addr(ROUTE_BASE, p), '0, $sformatf("route[%0d]", p));
            read_expect(port_addr(FWD_CNT_BASE, p), '0, $sformatf("fwd_cnt[%0d]", p));
            read_expect(port_addr(DROP_CNT_BASE, p), '0, $sformatf("drop_cnt[%0d]", p));
        end

        // Route table with the last port dropped, counters not writable
        for (int p = 0; p < NUM_PORTS; p++) begin
            rnd             = lcg_step(stim_state);
            route_m[p].dest = port_t'(rnd[9:8]);
            route_m[p].drop = (p == NUM_PORTS - 1);
            axil_write(port_addr(ROUTE_BASE, p), route_word(route_m[p]));
            read_expect(port_addr(ROUTE_BASE, p), route_word(route_m[p]),
                        $sformatf("route[%0d]", p));
            axil_write(port_addr(FWD_CNT_BASE, p), 32'hffff_0000 | p);
            axil_write(port_addr(DROP_CNT_BASE, p), 32'h0000_ffff | p);
            read_expect(port_addr(FWD_CNT_BASE, p), '0, $sformatf("fwd_cnt[%0d]", p));
            read_expect(port_addr(DROP_CNT_BASE, p), '0, $sformatf("drop_cnt[%0d]", p));
        end
        axil_write(CTRL_ADDR, 32'h1);
        enable_m = 1'b1;
        read_expect(CTRL_ADDR, 32'h1, "ctrl");

        for (int n = 0; n < FWD_PKTS; n++) begin
            rnd = lcg_step(stim_state);
            send_packet(port_t'(rnd[5:4]), int'(rnd[12:8]) % MAX_BEATS + 1);
        end

        // Everything dropped while disabled
        axil_write(CTRL_ADDR, 32'h0);
        enable_m = 1'b0;
        read_expect(CTRL_ADDR, 32'h0, "ctrl");
        for (int n = 0; n < OFF_PKTS; n++) begin
            rnd = lcg_step(stim_state);
            send_packet(port_t'(rnd[5:4]), int'(rnd[12:8]) % MAX_BEATS + 1);
        end

        while (exp_q.size() != 0) @(posedge axil_if);
        for (int p = 0; p < NUM_PORTS; p++) begin
            read_expect(port_addr(FWD_CNT_BASE, p), fwd_m[p], $sformatf("fwd_cnt[%0d]", p));
            read_expect(port_addr(DROP_CNT_BASE, p), drop_m[p], $sformatf("drop_cnt[%0d]", p));
        end
        $display("All tests passed");
        $finish;
    end

endmodule : tb

/* project.f */
smartnic_pkg.sv
steer_reg_pkg.sv
axis_if.sv
steer_cfg_if.sv
steer_regs.sv
port_steer.sv
steer_core.sv
tb.sv
